//--- flist.f
hdl/ram_pkg.sv
hdl/cfg_pkg.sv
hdl/ram_tile.sv
hdl/ram_wr_guard.sv
hdl/ram_bank_array.sv
hdl/ram_cfg_regs.sv
hdl/ram_top.sv
sim/ram_properties.sv
sim/ram_tb.sv

//--- hdl/cfg_pkg.sv
// --------------------
// Register map and widths of the RAM config block
// --------------------
`default_nettype none

package cfg_pkg;

  // --------------------
  // Register port widths
  // --------------------
  // Two registers in total
  localparam int CFG_ADDR_W = 1;
  localparam int CFG_DATA_W = 16;

  // --------------------
  // Register map
  // --------------------
  // Per-tile lock mask in the low bits
  // Upper bits read as zero
  localparam logic [CFG_ADDR_W-1:0] REG_LOCK = CFG_ADDR_W'(0);
  // Dropped-write count
  // Any write clears it
  localparam logic [CFG_ADDR_W-1:0] REG_DROPS = CFG_ADDR_W'(1);

  // Counter stops here
  localparam logic [CFG_DATA_W-1:0] DROP_MAX = {CFG_DATA_W{1'b1}};

endpackage : cfg_pkg

`default_nettype wire

//--- hdl/ram_bank_array.sv
// --------------------
// Four RAM tiles and the read mux across them
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_bank_array
  import ram_pkg::*;
(
  input  logic                 wr_clk,
  input  logic                 wr_rst,

  // Per-tile write enables from the guard
  input  logic [NUM_TILES-1:0] tile_wr_en,
  // Only the tile-internal bits are used here
  input  logic [ADDR_W-1:0]    wr_addr,
  input  logic [DATA_W-1:0]    wr_data,
  input  logic [NUM_WORDS-1:0] wr_word_en,

  // Read request and its same-cycle result
  input  logic                 rd_addr_valid,
  input  logic [ADDR_W-1:0]    rd_addr,
  output logic                 rd_data_valid,
  output logic [DATA_W-1:0]    rd_data
);

  // --------------------
  // Address split
  // --------------------
  logic [TILE_ADDR_W-1:0] wr_tile_addr;
  logic [TILE_ADDR_W-1:0] rd_tile_addr;
  // Upper read bits choose the tile output
  logic [TILE_SEL_W-1:0]  rd_tile_sel;

  assign wr_tile_addr = wr_addr[TILE_ADDR_W-1:0];
  assign rd_tile_addr = rd_addr[TILE_ADDR_W-1:0];
  assign rd_tile_sel  = rd_addr[ADDR_W-1:TILE_ADDR_W];

  // Read data of every tile
  logic [DATA_W-1:0] tile_rd_data [NUM_TILES];

  // --------------------
  // Tiles
  // --------------------
  // All tiles see the same address and data
  // Only the enabled one stores it
  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
    ram_tile ram_tile_i (
      .wr_clk     (wr_clk),
      .wr_rst     (wr_rst),
      .wr_valid   (tile_wr_en[t]),
      .wr_addr    (wr_tile_addr),
      .wr_data    (wr_data),
      .wr_word_en (wr_word_en),
      .rd_addr    (rd_tile_addr),
      .rd_data    (tile_rd_data[t])
    );
  end

  // --------------------
  // Read mux
  // --------------------
  // Zero-cycle read, valid follows the request
  assign rd_data       = tile_rd_data[rd_tile_sel];
  assign rd_data_valid = rd_addr_valid;

endmodule : ram_bank_array

`default_nettype wire

//--- hdl/ram_cfg_regs.sv
// --------------------
// Lock mask, dropped-write counter and register read-back
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_cfg_regs
  import ram_pkg::*;
  import cfg_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst,

  // Strobe-based register port
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  logic [CFG_ADDR_W-1:0] cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  // Read answer one cycle after cfg_rd
  output logic                  cfg_rvalid,
  output logic [CFG_DATA_W-1:0] cfg_rdata,

  // Dropped-write pulse from the guard
  input  logic                  drop,
  // Steers the write guard
  output logic [NUM_TILES-1:0]  lock_mask
);

  // Saturating count of dropped writes
  logic [CFG_DATA_W-1:0] drop_count;

  // Decoded write strobes
  logic lock_wr;
  logic drops_clr;

  assign lock_wr   = cfg_wr && (cfg_addr == REG_LOCK);
  assign drops_clr = cfg_wr && (cfg_addr == REG_DROPS);

  // --------------------
  // Lock mask
  // --------------------
  // New mask applies to writes in the next cycle
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      lock_mask <= '0;
    end else if (lock_wr) begin
      lock_mask <= cfg_wdata[NUM_TILES-1:0];
    end
  end

  // --------------------
  // Drop counter
  // --------------------
  // Clear has priority over a same-cycle drop
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      drop_count <= '0;
    end else if (drops_clr) begin
      drop_count <= '0;
    end else if (drop && (drop_count != DROP_MAX)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  // --------------------
  // Register read-back
  // --------------------
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_rd;
    end
  end

  // Data held between reads
  always_ff @(posedge wr_clk) begin
    if (cfg_rd) begin
      // Mask zero-extended to the register width
      cfg_rdata <= (cfg_addr == REG_LOCK) ? CFG_DATA_W'(lock_mask) : drop_count;
    end
  end

endmodule : ram_cfg_regs

`default_nettype wire

//--- hdl/ram_pkg.sv
// --------------------
// Geometry of the scratch RAM and of its flop tiles
// --------------------
`default_nettype none

package ram_pkg;

  // --------------------
  // Entry layout
  // --------------------
  // Full entry width in bits
  localparam int DATA_W = 32;
  // One byte lane per write enable bit
  localparam int WORD_W = 8;
  localparam int NUM_WORDS = DATA_W / WORD_W;

  // --------------------
  // Tile and array shape
  // --------------------
  // Entries held by one tile
  localparam int TILE_DEPTH = 16;
  localparam int TILE_ADDR_W = $clog2(TILE_DEPTH);
  localparam int NUM_TILES = 4;
  // Tile select sits in the upper address bits
  localparam int TILE_SEL_W = $clog2(NUM_TILES);
  localparam int DEPTH = TILE_DEPTH * NUM_TILES;
  localparam int ADDR_W = $clog2(DEPTH);

endpackage : ram_pkg

`default_nettype wire

//--- hdl/ram_tile.sv
// --------------------
// One 16-entry flop RAM tile
// Byte-lane writes, reset clear and a zero-latency read
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_tile
  import ram_pkg::*;
(
  input  logic                   wr_clk,
  // Synchronous, active high
  input  logic                   wr_rst,

  // Write port
  input  logic                   wr_valid,
  input  logic [TILE_ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0]      wr_data,
  // One bit per byte lane
  input  logic [NUM_WORDS-1:0]   wr_word_en,

  // Read port
  input  logic [TILE_ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0]      rd_data
);

  // --------------------
  // Storage
  // --------------------
  // Each entry split into lanes so a lane can be written alone
  logic [NUM_WORDS-1:0][WORD_W-1:0] mem [TILE_DEPTH];

  // Incoming data viewed as lanes
  logic [NUM_WORDS-1:0][WORD_W-1:0] wr_data_words;

  assign wr_data_words = wr_data;

  // --------------------
  // Write port
  // --------------------
  // Entry is stored at the edge that takes the write
  // Readable from the following cycle on
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      // Clear every entry
      for (int e = 0; e < TILE_DEPTH; e++) begin
        mem[e] <= '0;
      end
    end else if (wr_valid) begin
      // Only the enabled lanes change
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (wr_word_en[w]) begin
          mem[wr_addr][w] <= wr_data_words[w];
        end
      end
    end
  end

  // --------------------
  // Read port
  // --------------------
  // Plain index into the stored array
  // A same-cycle write to this entry is not forwarded
  // so the read still sees the old contents
  assign rd_data = mem[rd_addr];

endmodule : ram_tile

`default_nettype wire

//--- hdl/ram_top.sv
// --------------------
// Scratch RAM top with config block, write guard and bank array
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_top
  import ram_pkg::*;
  import cfg_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst,

  // RAM write port
  input  logic                  wr_valid,
  input  logic [ADDR_W-1:0]     wr_addr,
  input  logic [DATA_W-1:0]     wr_data,
  input  logic [NUM_WORDS-1:0]  wr_word_en,

  // RAM read port, zero latency
  input  logic                  rd_addr_valid,
  input  logic [ADDR_W-1:0]     rd_addr,
  output logic                  rd_data_valid,
  output logic [DATA_W-1:0]     rd_data,

  // Register port
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  logic [CFG_ADDR_W-1:0] cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  output logic                  cfg_rvalid,
  output logic [CFG_DATA_W-1:0] cfg_rdata
);

  // --------------------
  // Internal wires
  // --------------------
  logic [NUM_TILES-1:0] lock_mask;
  logic [NUM_TILES-1:0] tile_wr_en;
  // One pulse per write to a locked tile
  logic                 drop;

  // Lock mask and drop counter
  ram_cfg_regs ram_cfg_regs_i (
    .wr_clk     (wr_clk),
    .wr_rst     (wr_rst),
    .cfg_wr     (cfg_wr),
    .cfg_rd     (cfg_rd),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rvalid (cfg_rvalid),
    .cfg_rdata  (cfg_rdata),
    .drop       (drop),
    .lock_mask  (lock_mask)
  );

  // Tile decode and lock filter
  ram_wr_guard ram_wr_guard_i (
    .wr_valid   (wr_valid),
    .wr_addr    (wr_addr),
    .lock_mask  (lock_mask),
    .tile_wr_en (tile_wr_en),
    .drop       (drop)
  );

  // Storage and read path
  ram_bank_array ram_bank_array_i (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .tile_wr_en    (tile_wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

endmodule : ram_top

`default_nettype wire

//--- hdl/ram_wr_guard.sv
// --------------------
// Write guard that maps the address to a tile enable
// Locked tiles drop the write and raise drop
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_wr_guard
  import ram_pkg::*;
(
  // Write request from the external port
  input  logic                 wr_valid,
  input  logic [ADDR_W-1:0]    wr_addr,

  // Bit n set locks tile n
  input  logic [NUM_TILES-1:0] lock_mask,

  // One-hot enable toward the bank array
  output logic [NUM_TILES-1:0] tile_wr_en,
  // High for one cycle per dropped write
  output logic                 drop
);

  // Tile picked by the upper address bits
  logic [TILE_SEL_W-1:0] tile_sel;
  // Addressed tile is currently locked
  logic                  tile_locked;

  assign tile_sel    = wr_addr[ADDR_W-1:TILE_ADDR_W];
  assign tile_locked = lock_mask[tile_sel];

  // --------------------
  // Enable decode
  // --------------------
  always_comb begin
    tile_wr_en = '0;
    // Unlocked target gets its enable
    if (wr_valid && !tile_locked) begin
      tile_wr_en[tile_sel] = 1'b1;
    end
  end

  // Locked target
  // Counted by the config block at the next edge
  assign drop = wr_valid && tile_locked;

endmodule : ram_wr_guard

`default_nettype wire

//--- sim/ram_properties.sv
// --------------------
// Protocol assertions bound into the RAM top level
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_properties
  import cfg_pkg::*;
(
  input logic                  wr_clk,
  input logic                  wr_rst,
  input logic                  rd_addr_valid,
  input logic                  rd_data_valid,
  input logic                  cfg_wr,
  input logic                  cfg_rd,
  input logic [CFG_ADDR_W-1:0] cfg_addr,
  input logic                  cfg_rvalid,
  // Counter inside the config block
  input logic [CFG_DATA_W-1:0] drop_count
);

  // Failure count for the end-of-run summary
  int protocol_errors = 0;

  // Zero-latency read, valid is a plain copy in every cycle
  valid_copy: assert property (@(posedge wr_clk) rd_data_valid == rd_addr_valid)
    else begin
      protocol_errors++;
      $error("rd_data_valid does not follow rd_addr_valid");
    end

  // Register read answers exactly one cycle later
  rvalid_after_rd: assert property (@(posedge wr_clk) disable iff (wr_rst)
    cfg_rd |=> cfg_rvalid)
    else begin
      protocol_errors++;
      $error("cfg_rvalid missing one cycle after cfg_rd");
    end

  rvalid_only_after_rd: assert property (@(posedge wr_clk) disable iff (wr_rst)
    cfg_rvalid |-> $past(cfg_rd))
    else begin
      protocol_errors++;
      $error("cfg_rvalid raised without a cfg_rd in the cycle before");
    end

  // Count only moves up by one, unless cleared
  drops_monotonic: assert property (@(posedge wr_clk) disable iff (wr_rst)
    !$past(cfg_wr && (cfg_addr == REG_DROPS)) |->
      (drop_count >= $past(drop_count)) && (drop_count - $past(drop_count) <= 1))
    else begin
      protocol_errors++;
      $error("drop count decreased or jumped without a clear");
    end

endmodule : ram_properties

bind ram_top ram_properties ram_properties_i (
  .wr_clk        (wr_clk),
  .wr_rst        (wr_rst),
  .rd_addr_valid (rd_addr_valid),
  .rd_data_valid (rd_data_valid),
  .cfg_wr        (cfg_wr),
  .cfg_rd        (cfg_rd),
  .cfg_addr      (cfg_addr),
  .cfg_rvalid    (cfg_rvalid),
  .drop_count    (ram_cfg_regs_i.drop_count)
);

`default_nettype wire

//--- sim/ram_tb.sv
// --------------------
// Testbench for the scratch RAM with shadow model and checks
// --------------------
`default_nettype none
`timescale 1ns/1ps

module ram_tb
  import ram_pkg::*;
  import cfg_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 3000;
  // Random ops per test phase
  localparam int NUM_OPS = 150;

  logic                  wr_clk;
  logic                  wr_rst;
  logic                  wr_valid;
  logic [ADDR_W-1:0]     wr_addr;
  logic [DATA_W-1:0]     wr_data;
  logic [NUM_WORDS-1:0]  wr_word_en;
  logic                  rd_addr_valid;
  logic [ADDR_W-1:0]     rd_addr;
  logic                  rd_data_valid;
  logic [DATA_W-1:0]     rd_data;
  logic                  cfg_wr;
  logic                  cfg_rd;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  cfg_rvalid;
  logic [CFG_DATA_W-1:0] cfg_rdata;

  ram_top ram_top_i (.*);

  // --------------------
  // Shadow model
  // --------------------
  logic [DATA_W-1:0]     shadow_mem [DEPTH];
  logic [NUM_TILES-1:0]  shadow_lock = '0;
  logic [CFG_DATA_W-1:0] shadow_drops = '0;
  // Ops driven last cycle, taken at the coming edge
  logic                  pend_wv = 1'b0;
  logic [ADDR_W-1:0]     pend_wa = '0;
  logic [DATA_W-1:0]     pend_wd = '0;
  logic [NUM_WORDS-1:0]  pend_we = '0;
  logic                  pend_cw = 1'b0;
  logic [CFG_ADDR_W-1:0] pend_ca = '0;
  logic [CFG_DATA_W-1:0] pend_cd = '0;
  // Expected results
  logic [DATA_W-1:0]     exp_rd_data = '0;
  logic [CFG_DATA_W-1:0] exp_cfg_d = '0;
  logic [CFG_DATA_W-1:0] exp_cfg_q = '0;

  integer seed = 32'hd39e;
  int     mismatch_errors = 0;
  int     timeout_errors = 0;
  int     cycle_count = 0;

  initial begin
    wr_clk = 1'b0;
    forever #10 wr_clk = ~wr_clk;
  end

  // Register answer lands one cycle after the request
  always @(posedge wr_clk) begin
    exp_cfg_q <= exp_cfg_d;
  end

  // --------------------
  // Checks
  // --------------------
  rd_data_check: assert property (@(posedge wr_clk) disable iff (wr_rst)
    rd_addr_valid |-> (rd_data == exp_rd_data))
    else begin
      mismatch_errors++;
      $display("MISMATCH at %0t: rd_data got %h expected %h",
               $time, $sampled(rd_data), $sampled(exp_rd_data));
    end

  cfg_rdata_check: assert property (@(posedge wr_clk) disable iff (wr_rst)
    cfg_rvalid |-> (cfg_rdata == exp_cfg_q))
    else begin
      mismatch_errors++;
      $display("MISMATCH at %0t: cfg_rdata got %h expected %h",
               $time, $sampled(cfg_rdata), $sampled(exp_cfg_q));
    end

  always @(posedge wr_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      timeout_errors++;
      $display("Timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  // --------------------
  // Tasks
  // --------------------
  // Apply the ops taken at this edge to the model
  task automatic commit_pending();
    int   tile;
    logic dropped;
    tile    = int'(pend_wa) / TILE_DEPTH;
    dropped = pend_wv && shadow_lock[tile];
    if (pend_wv && !dropped) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        if (pend_we[i]) shadow_mem[pend_wa][i*WORD_W +: WORD_W] = pend_wd[i*WORD_W +: WORD_W];
      end
    end
    // Clear beats a same-cycle drop
    if (pend_cw && (pend_ca == REG_DROPS)) begin
      shadow_drops = '0;
    end else if (dropped && (shadow_drops != DROP_MAX)) begin
      shadow_drops = shadow_drops + 1'b1;
    end
    // Old mask still guarded the write above
    if (pend_cw && (pend_ca == REG_LOCK)) shadow_lock = pend_cd[NUM_TILES-1:0];
  endtask

  // One clock of stimulus
  task automatic do_cycle(
    input logic                  wv,
    input logic [ADDR_W-1:0]     wa,
    input logic [DATA_W-1:0]     wd,
    input logic [NUM_WORDS-1:0]  we,
    input logic                  rv,
    input logic [ADDR_W-1:0]     ra,
    input logic                  cw,
    input logic                  cr,
    input logic [CFG_ADDR_W-1:0] ca,
    input logic [CFG_DATA_W-1:0] cd
  );
    @(posedge wr_clk);
    commit_pending();
    wr_valid      <= wv;
    wr_addr       <= wa;
    wr_data       <= wd;
    wr_word_en    <= we;
    rd_addr_valid <= rv;
    rd_addr       <= ra;
    cfg_wr        <= cw;
    cfg_rd        <= cr;
    cfg_addr      <= ca;
    cfg_wdata     <= cd;
    // Read sees memory before this cycle's write
    exp_rd_data   <= shadow_mem[ra];
    if (cr) exp_cfg_d <= (ca == REG_LOCK) ? CFG_DATA_W'(shadow_lock) : shadow_drops;
    pend_wv = wv;
    pend_wa = wa;
    pend_wd = wd;
    pend_we = we;
    pend_cw = cw;
    pend_ca = ca;
    pend_cd = cd;
  endtask

  task automatic read_ram(input logic [ADDR_W-1:0] a);
    do_cycle(1'b0, '0, '0, '0, 1'b1, a, 1'b0, 1'b0, REG_LOCK, '0);
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] a, input logic [CFG_DATA_W-1:0] d);
    do_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, 1'b0, a, d);
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] a);
    do_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1, a, '0);
  endtask

  // Random write plus read, half of the reads hit the written entry
  task automatic random_op();
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_ctl;
    logic [31:0] r_rd;
    r_addr = $random(seed);
    r_data = $random(seed);
    r_ctl  = $random(seed);
    r_rd   = r_ctl[4] ? r_addr : $random(seed);
    do_cycle(r_ctl[6:5] != 2'b00, r_addr[ADDR_W-1:0], r_data, r_ctl[NUM_WORDS-1:0],
             1'b1, r_rd[ADDR_W-1:0], 1'b0, 1'b0, REG_LOCK, '0);
  endtask

  task automatic finish_run();
    int protocol_errors;
    protocol_errors = ram_top_i.ram_properties_i.protocol_errors;
    $display("Errors: %0d mismatch, %0d protocol, %0d timeout",
             mismatch_errors, protocol_errors, timeout_errors);
    if (mismatch_errors + protocol_errors + timeout_errors == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    logic [31:0] lock_sel;
    wr_rst        = 1'b1;
    wr_valid      = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_word_en    = '0;
    rd_addr_valid = 1'b0;
    rd_addr       = '0;
    cfg_wr        = 1'b0;
    cfg_rd        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    for (int a = 0; a < DEPTH; a++) shadow_mem[a] = '0;
    repeat (8) @(posedge wr_clk);
    wr_rst <= 1'b0;
    // Every entry cleared by reset
    for (int a = 0; a < DEPTH; a++) read_ram(ADDR_W'(a));
    cfg_read(REG_LOCK);
    cfg_read(REG_DROPS);
    repeat (2 * NUM_OPS) random_op();
    // One tile locked
    lock_sel = $random(seed);
    cfg_write(REG_LOCK, CFG_DATA_W'(1 << lock_sel[TILE_SEL_W-1:0]));
    repeat (NUM_OPS) random_op();
    cfg_read(REG_DROPS);
    cfg_read(REG_LOCK);
    // Tiles 0 and 2, upper bits ignored
    cfg_write(REG_LOCK, 16'hfff5);
    repeat (NUM_OPS) random_op();
    cfg_read(REG_DROPS);
    cfg_read(REG_LOCK);
    // Clear together with a dropped write to tile 0
    do_cycle(1'b1, ADDR_W'(3), 32'hdead_beef, '1, 1'b0, '0, 1'b1, 1'b0, REG_DROPS, '0);
    cfg_read(REG_DROPS);
    cfg_write(REG_LOCK, '0);
    repeat (NUM_OPS) random_op();
    for (int a = 0; a < DEPTH; a++) read_ram(ADDR_W'(a));
    cfg_read(REG_DROPS);
    repeat (3) do_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0, REG_LOCK, '0);
    finish_run();
  end

endmodule : ram_tb

`default_nettype wire
